// File: dv/tb_top.sv
`timescale 1ns/1ps

module tb_top;

  localparam int CLK_NS      = 4;
  localparam int REQ_CYCLES  = 12;
  localparam int SCK_HALF    = 8;              // clk cycles per SCK phase
  localparam int SPI_BYTES   = 19;             // bytes sent over the whole run
  localparam int BYTE_NS     = 8 * 2 * SCK_HALF * CLK_NS;
  localparam int WATCHDOG_NS = SPI_BYTES * BYTE_NS * 20;  // about 200 us
  localparam int DONE_LIMIT  = 2 + 4;          // sync stages plus allowed latency

  // reply and status bytes the DUT must return
  localparam logic [7:0]  EXP_COOKIE  = 8'haf;
  localparam logic [7:0]  EXP_VERSION = 8'h03;
  localparam logic [7:0]  EXP_BUSY    = 8'hf0;
  localparam logic [7:0]  EXP_READY   = 8'h30;
  localparam logic [15:0] TRS_PORT    = 16'h001f;
  localparam logic [15:0] PRN_ADDR    = 16'h37e8;
  localparam logic [3:0]  S_TRS_IN    = 4'd0;
  localparam logic [3:0]  S_TRS_OUT   = 4'd1;
  localparam logic [3:0]  S_FRE_IN    = 4'd2;
  localparam logic [3:0]  S_PRN       = 4'd4;
  localparam logic [3:0]  S_NONE      = 4'hf;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        spi_sck, spi_mosi, spi_cs_n, spi_miso;
  logic        esp_done, in_n, out_n, wr_n, rd_n;
  logic [15:0] bus_addr;
  logic [7:0]  bus_data, bus_dout;
  logic        esp_req, wait_out, io_int, key_any;
  logic [3:0]  esp_s;
  logic [23:0] screen_color;

  int          errors = 0;
  int          checks = 0;
  int          req_len;
  logic [31:0] lfsr = 32'heb82;

  always #(CLK_NS / 2) clk = ~clk;

  trs_esp_top #(.REQ_PULSE_CYCLES(REQ_CYCLES)) UUT (.*);

  // galois step, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  task automatic draw(input int nbits, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = lfsr_next(lfsr);  // one step per bit
      v = {v[14:0], lfsr[0]};
    end
  endtask

  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #1;  // drive and look just after the edge
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // one byte, MSB first; host samples MISO as it raises SCK
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    rx = '0;
    for (int i = 7; i >= 0; i--) begin
      spi_mosi = tx[i];
      tick(SCK_HALF);
      rx = {rx[6:0], spi_miso};
      spi_sck = 1'b1;
      tick(SCK_HALF);
      spi_sck = 1'b0;  // slave shifts on this edge
    end
  endtask

  task automatic spi_frame(input logic [7:0] b0, input logic [7:0] b1, input logic [7:0] b2,
                           input logic [7:0] b3, input int n, output logic [7:0] rx_last);
    logic [7:0] tx [4];
    logic [7:0] rx;
    tx[0] = b0;
    tx[1] = b1;
    tx[2] = b2;
    tx[3] = b3;
    rx = '0;
    spi_cs_n = 1'b0;
    tick(4);
    for (int i = 0; i < n; i++) begin
      spi_byte(tx[i], rx);
    end
    rx_last = rx;
    tick(4);
    spi_cs_n = 1'b1;
    tick(8);
  endtask

  task automatic get_reply(input logic [7:0] op, output logic [7:0] r);
    spi_frame(op, 8'h00, 8'h00, 8'h00, 2, r);  // command + dummy byte
  endtask

  // full Z80 port cycle: strobe, WAIT, co-processor done, release
  task automatic io_access(input logic [15:0] addr, input logic is_in, input logic [3:0] code);
    int n;
    bus_addr = addr;
    if (is_in) begin
      in_n = 1'b0;
    end else begin
      out_n = 1'b0;
    end
    n = 0;
    while (!esp_req && n < 4) begin
      tick(1);
      n++;
    end
    check_eq(esp_req, 1, "esp_req after port access");
    check_eq(wait_out, 1, "wait_out during port access");
    check_eq(esp_s, code, "esp_s during port access");
    n = 0;
    while (esp_req && n < REQ_CYCLES + 4) begin
      tick(1);
      n++;
    end
    esp_done = 1'b1;
    n = 0;
    while (wait_out && n < DONE_LIMIT) begin
      tick(1);
      n++;
    end
    check_eq(wait_out, 0, "wait_out after esp_done");
    esp_done = 1'b0;
    in_n     = 1'b1;
    out_n    = 1'b1;
    tick(4);  // let the select sync chain drain
    check_eq(esp_s, S_NONE, "esp_s after port access");
  endtask

  // pulse length counter for the esp_req assertion
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_len <= 0;
    end else begin
      req_len <= esp_req ? req_len + 1 : 0;
    end
  end

  a_req_len : assert property (@(posedge clk) disable iff (!arst_n)
    $fell(esp_req) |-> (req_len == REQ_CYCLES))
    else begin
      errors++;
      $display("Error at time %0t: esp_req pulse length differs from %0d cycles", $time,
               REQ_CYCLES);
    end

  a_wait_with_req : assert property (@(posedge clk) disable iff (!arst_n)
    $rose(wait_out) |-> $rose(esp_req))
    else begin
      errors++;
      $display("Error at time %0t: wait_out rose without a new esp_req", $time);
    end

  // CS seen through two sync flops
  a_miso_idle : assert property (@(posedge clk) disable iff (!arst_n)
    $past(spi_cs_n, 2) |-> !spi_miso)
    else begin
      errors++;
      $display("Error at time %0t: spi_miso high while CS inactive", $time);
    end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired: the test did not reach its end in time");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    logic [7:0]  r;
    logic [15:0] v;
    logic [7:0]  c0, c1, c2, mask, prn;
    int          n;
    arst_n   = 1'b0;
    spi_sck  = 1'b0;
    spi_mosi = 1'b0;
    spi_cs_n = 1'b1;
    esp_done = 1'b0;
    bus_addr = '0;
    bus_data = '0;
    in_n     = 1'b1;
    out_n    = 1'b1;
    wr_n     = 1'b1;
    rd_n     = 1'b1;
    repeat (10) @(posedge clk);
    #1 arst_n = 1'b1;
    tick(2);

    // reset values
    check_eq(esp_req, 0, "esp_req after reset");
    check_eq(wait_out, 0, "wait_out after reset");
    check_eq(io_int, 0, "io_int after reset");
    check_eq(esp_s, S_NONE, "esp_s after reset");
    check_eq(screen_color, 24'hff_ffff, "screen_color after reset");
    check_eq(key_any, 0, "key_any after reset");
    check_eq(spi_miso, 0, "spi_miso after reset");

    // cookie waits in the shifter across a CS-high gap
    spi_frame(8'd0, 8'h00, 8'h00, 8'h00, 1, r);
    spi_frame(8'h00, 8'h00, 8'h00, 8'h00, 1, r);  // host dummy byte clocks it out
    check_eq(r, EXP_COOKIE, "get_cookie reply");
    get_reply(8'd15, r);
    check_eq(r, EXP_VERSION, "get_version reply");

    // screen color, msb byte first
    draw(8, v);
    c0 = v[7:0];
    draw(8, v);
    c1 = v[7:0];
    draw(8, v);
    c2 = v[7:0];
    spi_frame(8'd17, c0, c1, c2, 4, r);
    check_eq(screen_color, {c0, c1, c2}, "screen_color");

    // keyboard row 7
    draw(8, v);
    mask = (v[7:0] == 8'h00) ? 8'h01 : v[7:0];
    spi_frame(8'd19, 8'd7, mask, 8'h00, 3, r);
    check_eq(key_any, 1, "key_any after key press");
    spi_frame(8'd19, 8'd7, 8'h00, 8'h00, 3, r);
    check_eq(key_any, 0, "key_any after key release");

    io_access(TRS_PORT, 1'b0, S_TRS_OUT);
    draw(4, v);
    io_access({8'h00, 4'hc, v[3:0]}, 1'b1, S_FRE_IN);  // random FreHD port

    // printer write, no WAIT
    draw(8, v);
    prn      = v[7:0];
    bus_addr = PRN_ADDR;
    bus_data = prn;
    wr_n     = 1'b0;
    n = 0;
    while (!esp_req && n < 4) begin
      tick(1);
      n++;
    end
    check_eq(esp_req, 1, "esp_req after printer write");
    check_eq(wait_out, 0, "wait_out on printer write");
    check_eq(esp_s, S_PRN, "esp_s on printer write");
    tick(2);
    wr_n = 1'b1;
    n = 0;
    while (esp_req && n < REQ_CYCLES + 4) begin
      tick(1);
      n++;
    end
    rd_n = 1'b0;
    tick(1);
    check_eq(bus_dout, EXP_BUSY, "printer status while pending");
    check_eq(esp_s, S_PRN, "esp_s while printer byte pending");
    rd_n = 1'b1;
    tick(1);
    check_eq(bus_dout, 8'h00, "bus_dout with rd_n high");
    get_reply(8'd16, r);
    check_eq(r, prn, "get_printer_byte reply");
    rd_n     = 1'b0;
    esp_done = 1'b1;
    n = 0;
    while (bus_dout !== EXP_READY && n < DONE_LIMIT) begin
      tick(1);
      n++;
    end
    check_eq(bus_dout, EXP_READY, "printer status after esp_done");
    esp_done = 1'b0;
    rd_n     = 1'b1;
    tick(1);
    check_eq(esp_s, S_NONE, "esp_s after printer done");

    // data-ready interrupt, cleared by a TRS-IO access
    spi_frame(8'd5, 8'h00, 8'h00, 8'h00, 1, r);
    check_eq(io_int, 1, "io_int after data_ready");
    io_access(TRS_PORT, 1'b1, S_TRS_IN);
    check_eq(io_int, 0, "io_int after IN from port 31");

    draw(16, v);
    bus_addr = v;  // strobes idle, no select
    get_reply(8'd18, r);
    check_eq(r, v[7:0], "abus_read reply");

    tick(10);
    $display("end of test: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
src/trs_esp_pkg.sv
src/spi_link_if.sv
src/cmd_bus_if.sv
src/esp_spi_slave.sv
src/cmd_parser.sv
src/cfg_regs.sv
src/io_bridge.sv
src/trs_esp_top.sv
dv/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
    -f flist.f -o tb_top_sim; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_top_sim)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1

// File: src/cfg_regs.sv
`timescale 1ns/1ps

module cfg_regs (
  input  logic        clk,
  input  logic        arst_n,
  cmd_bus_if.regs     cmd,
  input  logic [7:0]  printer_byte,  // buffered byte from the bridge
  input  logic [7:0]  bus_addr_lo,
  output logic [23:0] screen_color,
  output logic        key_any
);

  logic [7:0][7:0] keyb;  // 8 rows of 8 keys
  logic [7:0]      reply_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      screen_color <= 24'hff_ffff;  // white
      keyb         <= '0;
    end else if (cmd.action) begin
      case (cmd.cmd)
        trs_esp_pkg::set_screen_color: begin
          screen_color <= {cmd.params[0], cmd.params[1], cmd.params[2]};  // r,g,b
        end
        trs_esp_pkg::send_keyb: begin
          keyb[cmd.params[0][2:0]] <= cmd.params[1];  // row, mask
        end
        default: ;
      endcase
    end
  end

  assign key_any = |keyb;  // any key in any row

  // reply byte, ready the cycle after action
  always_ff @(posedge clk) begin
    if (cmd.action) begin
      case (cmd.cmd)
        trs_esp_pkg::get_cookie:       reply_q <= trs_esp_pkg::COOKIE;
        trs_esp_pkg::get_version:      reply_q <= trs_esp_pkg::VERSION_BYTE;
        trs_esp_pkg::get_printer_byte: reply_q <= printer_byte;
        trs_esp_pkg::abus_read:        reply_q <= bus_addr_lo;
        default: ;  // no reply, keep last
      endcase
    end
  end

  assign cmd.reply = reply_q;

endmodule

// File: src/cmd_bus_if.sv
`timescale 1ns/1ps

// decoded command from the parser, reply back from the register block
interface cmd_bus_if;

  logic                                    action;  // one-cycle strobe, cmd/params valid
  trs_esp_pkg::cmd_e                       cmd;
  logic [trs_esp_pkg::MAX_PARAMS-1:0][7:0] params;  // params[0] is first byte received
  logic [7:0]                              reply;   // registered after action

  modport parser (output action, output cmd, output params, input reply);
  modport regs   (input action, input cmd, input params, output reply);
  modport bridge (input action, input cmd);  // only needs data_ready

endinterface

// File: src/cmd_parser.sv
`timescale 1ns/1ps

module cmd_parser (
  input  logic       clk,
  input  logic       arst_n,
  spi_link_if.parser link,
  cmd_bus_if.parser  cmd
);

  trs_esp_pkg::parse_state_e state;
  trs_esp_pkg::cmd_e         cmd_q;
  logic [3:0]                info;        // {known, reply, param count}
  logic [1:0]                param_idx;
  logic [1:0]                param_left;
  logic [1:0]                reply_pipe;  // action -> reply reg -> tx_load
  logic [trs_esp_pkg::MAX_PARAMS-1:0][7:0] params_q;

  // per-opcode table
  function automatic logic [3:0] op_table(input logic [7:0] op);
    logic [3:0] r;
    case (op)
      trs_esp_pkg::get_cookie,
      trs_esp_pkg::get_version,
      trs_esp_pkg::get_printer_byte,
      trs_esp_pkg::abus_read:        r = 4'b1100;  // reply, no params
      trs_esp_pkg::data_ready:       r = 4'b1000;
      trs_esp_pkg::set_screen_color: r = 4'b1011;  // r, g, b
      trs_esp_pkg::send_keyb:        r = 4'b1010;  // row, mask
      default:                       r = 4'b0000;  // unknown
    endcase
    return r;
  endfunction

  assign info = op_table(link.rx_byte);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= trs_esp_pkg::idle;
      cmd_q      <= trs_esp_pkg::get_cookie;
      param_idx  <= '0;
      param_left <= '0;
      reply_pipe <= '0;
      cmd.action <= 1'b0;
      link.tx_load <= 1'b0;
    end else begin
      cmd.action   <= 1'b0;  // strobes by default
      link.tx_load <= reply_pipe[1];
      reply_pipe   <= {reply_pipe[0], 1'b0};
      case (state)
        trs_esp_pkg::idle: begin
          if (link.rx_valid && info[3]) begin
            cmd_q <= trs_esp_pkg::cmd_e'(link.rx_byte);
            if (info[1:0] == 2'd0) begin
              cmd.action    <= 1'b1;
              reply_pipe[0] <= info[2];
            end else begin
              state      <= trs_esp_pkg::read_params;
              param_idx  <= '0;
              param_left <= info[1:0];
            end
          end
        end
        trs_esp_pkg::read_params: begin
          if (link.rx_valid) begin
            param_idx <= param_idx + 2'd1;
            if (param_left == 2'd1) begin
              cmd.action <= 1'b1;  // last param in
              state      <= trs_esp_pkg::idle;
            end else begin
              param_left <= param_left - 2'd1;
            end
          end
        end
        trs_esp_pkg::send_reply: begin
          if (link.rx_valid) begin
            state <= trs_esp_pkg::idle;  // host dummy byte, dropped
          end
        end
        default: state <= trs_esp_pkg::idle;
      endcase
      if (reply_pipe[1]) begin
        state <= trs_esp_pkg::send_reply;  // reply goes out with the dummy byte
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == trs_esp_pkg::read_params && link.rx_valid) begin
      params_q[param_idx] <= link.rx_byte;
    end
  end

  assign cmd.cmd      = cmd_q;
  assign cmd.params   = params_q;
  assign link.tx_byte = cmd.reply;

  a_action_single : assert property (@(posedge clk) disable iff (!arst_n)
    cmd.action |=> !cmd.action);

endmodule

// File: src/esp_spi_slave.sv
`timescale 1ns/1ps

module esp_spi_slave (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      spi_sck,
  input  logic      spi_mosi,
  input  logic      spi_cs_n,
  output logic      spi_miso,
  spi_link_if.slave link
);

  logic [2:0] sck_q;      // 2 sync stages + 1 for edge detect
  logic [1:0] mosi_q;
  logic [1:0] cs_q;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;
  logic [2:0] bit_cnt;
  logic [7:0] shift_in;
  logic [7:0] shift_out;
  logic       rise_seen;  // a rising edge came after the last load

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sck_q  <= '0;
      mosi_q <= '0;
      cs_q   <= 2'b11;  // deselected
    end else begin
      sck_q  <= {sck_q[1:0], spi_sck};
      mosi_q <= {mosi_q[0], spi_mosi};
      cs_q   <= {cs_q[0], spi_cs_n};
    end
  end

  assign sck_rise  = (sck_q[2:1] == 2'b01);
  assign sck_fall  = (sck_q[2:1] == 2'b10);
  assign cs_active = ~cs_q[1];

  // receive side, MSB first, sampled on rising SCK
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt       <= '0;
      link.rx_valid <= 1'b0;
    end else begin
      link.rx_valid <= cs_active && sck_rise && (bit_cnt == 3'd7);
      if (!cs_active) begin
        bit_cnt <= '0;  // frame boundary
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      shift_in <= {shift_in[6:0], mosi_q[1]};
    end
  end

  assign link.rx_byte = shift_in;  // complete while rx_valid is high

  // transmit side
  // the load usually lands before the trailing falling edge of the command
  // byte, so that edge must not shift; only falls after a new rise count
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      shift_out <= '0;
      rise_seen <= 1'b0;
    end else if (link.tx_load) begin
      shift_out <= link.tx_byte;  // bit 7 on MISO right away
      rise_seen <= 1'b0;
    end else begin
      if (sck_rise) begin
        rise_seen <= 1'b1;
      end
      if (cs_active && sck_fall && rise_seen) begin
        shift_out <= {shift_out[6:0], 1'b0};
      end
    end
  end

  assign spi_miso = cs_active & shift_out[7];  // low when deselected

  // a byte strobe needs CS low at the pin 3 clocks back, through the sync chain
  a_rx_needs_cs : assert property (@(posedge clk) disable iff (!arst_n)
    link.rx_valid |-> $past(!spi_cs_n, 3));

endmodule

// File: src/io_bridge.sv
`timescale 1ns/1ps

module io_bridge #(
  parameter int REQ_PULSE_CYCLES = 50
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [15:0] bus_addr,
  input  logic [7:0]  bus_data,
  input  logic        in_n,
  input  logic        out_n,
  input  logic        wr_n,
  input  logic        rd_n,
  input  logic        esp_done,
  output logic        esp_req,
  output logic [3:0]  esp_s,
  output logic        wait_out,
  output logic        io_int,
  output logic [7:0]  bus_dout,
  output logic [7:0]  printer_byte,
  cmd_bus_if.bridge   cmd
);

  localparam int CW = $clog2(REQ_PULSE_CYCLES + 1);
  localparam logic [CW-1:0] PULSE_LEN = CW'(REQ_PULSE_CYCLES);

  // select vector bit positions
  localparam int SEL_TRS_IN  = 0;
  localparam int SEL_TRS_OUT = 1;
  localparam int SEL_FRE_IN  = 2;
  localparam int SEL_FRE_OUT = 3;
  localparam int SEL_PRN     = 4;

  logic [4:0]            sel_raw;
  logic [4:0]            sel_s1, sel_s2, sel_s3;
  logic [4:0]            sel_rise;
  logic                  access;
  logic [2:0]            done_q;
  logic                  done_rise;
  logic [CW-1:0]         cnt;
  logic                  prn_pending;
  logic [7:0]            prn_status;
  trs_esp_pkg::esp_sel_e sel_code;

  // port and address decode, straight from the pins
  assign sel_raw[SEL_TRS_IN]  = (bus_addr[7:0] == trs_esp_pkg::TRS_IO_PORT) && !in_n;
  assign sel_raw[SEL_TRS_OUT] = (bus_addr[7:0] == trs_esp_pkg::TRS_IO_PORT) && !out_n;
  assign sel_raw[SEL_FRE_IN]  = (bus_addr[7:4] == trs_esp_pkg::FREHD_PORT_HI) && !in_n;
  assign sel_raw[SEL_FRE_OUT] = (bus_addr[7:4] == trs_esp_pkg::FREHD_PORT_HI) && !out_n;
  assign sel_raw[SEL_PRN]     = (bus_addr == trs_esp_pkg::PRINTER_ADDR) && !wr_n;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sel_s1 <= '0;
      sel_s2 <= '0;
      sel_s3 <= '0;
      done_q <= '0;
    end else begin
      sel_s1 <= sel_raw;
      sel_s2 <= sel_s1;
      sel_s3 <= sel_s2;  // edge detect stage
      done_q <= {done_q[1:0], esp_done};
    end
  end

  assign sel_rise  = sel_s2 & ~sel_s3;
  assign access    = |sel_rise;
  assign done_rise = (done_q[2:1] == 2'b01);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      esp_req     <= 1'b0;
      cnt         <= '0;
      wait_out    <= 1'b0;
      prn_pending <= 1'b0;
      prn_status  <= trs_esp_pkg::PRN_READY;
    end else begin
      if (access) begin
        esp_req <= 1'b1;
        cnt     <= PULSE_LEN;  // restarts on back-to-back access
        if (sel_rise[SEL_PRN]) begin
          prn_pending <= 1'b1;  // no WAIT for the printer
          prn_status  <= trs_esp_pkg::PRN_BUSY;
        end else begin
          wait_out <= 1'b1;  // hold the Z80 until done
        end
      end else begin
        if (cnt == CW'(1)) begin
          esp_req <= 1'b0;
        end
        if (cnt != '0) begin
          cnt <= cnt - CW'(1);
        end
        if (done_rise) begin
          wait_out    <= 1'b0;
          prn_pending <= 1'b0;
          prn_status  <= trs_esp_pkg::PRN_READY;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sel_rise[SEL_PRN]) begin
      printer_byte <= bus_data;  // one byte buffer
    end
  end

  // data-ready flag, cleared by the next TRS-IO access
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      io_int <= 1'b0;
    end else if (cmd.action && cmd.cmd == trs_esp_pkg::data_ready) begin
      io_int <= 1'b1;
    end else if (sel_rise[SEL_TRS_IN] || sel_rise[SEL_TRS_OUT]) begin
      io_int <= 1'b0;
    end
  end

  always_comb begin
    if (sel_s2[SEL_TRS_IN]) begin
      sel_code = trs_esp_pkg::trs_io_in;
    end else if (sel_s2[SEL_TRS_OUT]) begin
      sel_code = trs_esp_pkg::trs_io_out;
    end else if (sel_s2[SEL_FRE_IN]) begin
      sel_code = trs_esp_pkg::frehd_in;
    end else if (sel_s2[SEL_FRE_OUT]) begin
      sel_code = trs_esp_pkg::frehd_out;
    end else if (prn_pending) begin
      sel_code = trs_esp_pkg::printer_wr;
    end else begin
      sel_code = trs_esp_pkg::none;
    end
  end

  assign esp_s = sel_code;

  // printer status readback
  assign bus_dout = (bus_addr == trs_esp_pkg::PRINTER_ADDR && !rd_n) ? prn_status : 8'h00;

  // printer writes at the pins must never lead to WAIT
  a_no_wait_prn : assert property (@(posedge clk) disable iff (!arst_n)
    (!wr_n && bus_addr == trs_esp_pkg::PRINTER_ADDR) |-> !$rose(wait_out));

endmodule

// File: src/spi_link_if.sv
`timescale 1ns/1ps

// byte level link between the SPI slave and the parser
interface spi_link_if;

  logic [7:0] rx_byte;   // last complete byte from MOSI
  logic       rx_valid;  // one-cycle pulse per byte
  logic [7:0] tx_byte;   // reply byte for MISO
  logic       tx_load;   // one-cycle pulse, loads tx_byte

  modport slave  (output rx_byte, output rx_valid, input tx_byte, input tx_load);
  modport parser (input rx_byte, input rx_valid, output tx_byte, output tx_load);

endinterface

// File: src/trs_esp_pkg.sv
package trs_esp_pkg;

  // command opcodes sent by the co-processor over SPI
  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    data_ready       = 8'd5,
    get_version      = 8'd15,
    get_printer_byte = 8'd16,
    set_screen_color = 8'd17,
    abus_read        = 8'd18,
    send_keyb        = 8'd19
  } cmd_e;

  // command parser FSM
  typedef enum logic [1:0] {
    idle,
    read_params,  // collecting parameter bytes
    send_reply    // waiting out the host dummy byte
  } parse_state_e;

  // selection code shown to the co-processor on esp_s
  typedef enum logic [3:0] {
    trs_io_in  = 4'd0,
    trs_io_out = 4'd1,
    frehd_in   = 4'd2,
    frehd_out  = 4'd3,
    printer_wr = 4'd4,
    none       = 4'hf   // nothing selected
  } esp_sel_e;

  localparam logic [7:0] COOKIE       = 8'haf;
  localparam logic [7:0] VERSION_BYTE = 8'h03;  // major 3 bits, minor 5 bits

  // printer status as read back by the Z80
  localparam logic [7:0] PRN_READY = 8'h30;
  localparam logic [7:0] PRN_BUSY  = 8'hf0;

  localparam logic [7:0]  TRS_IO_PORT   = 8'd31;
  localparam logic [3:0]  FREHD_PORT_HI = 4'hc;   // ports 0xC0..0xCF
  localparam logic [15:0] PRINTER_ADDR  = 16'h37e8;

  localparam int MAX_PARAMS = 3;  // longest command is set_screen_color

endpackage

// File: src/trs_esp_top.sv
`timescale 1ns/1ps

module trs_esp_top #(
  parameter int REQ_PULSE_CYCLES = 50  // esp_req width in clk cycles
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        spi_sck,
  input  logic        spi_mosi,
  input  logic        spi_cs_n,
  input  logic        esp_done,
  input  logic [15:0] bus_addr,
  input  logic [7:0]  bus_data,
  input  logic        in_n,
  input  logic        out_n,
  input  logic        wr_n,
  input  logic        rd_n,
  output logic        spi_miso,
  output logic        esp_req,
  output logic [3:0]  esp_s,
  output logic        wait_out,
  output logic        io_int,
  output logic [7:0]  bus_dout,
  output logic [23:0] screen_color,
  output logic        key_any
);

  logic [7:0] printer_byte;  // bridge buffer -> get_printer_byte reply

  spi_link_if link ();
  cmd_bus_if  cmd_bus ();

  esp_spi_slave u_spi (
    .clk      (clk),
    .arst_n   (arst_n),
    .spi_sck  (spi_sck),
    .spi_mosi (spi_mosi),
    .spi_cs_n (spi_cs_n),
    .spi_miso (spi_miso),
    .link     (link.slave)
  );

  cmd_parser u_parser (
    .clk    (clk),
    .arst_n (arst_n),
    .link   (link.parser),
    .cmd    (cmd_bus.parser)
  );

  cfg_regs u_regs (
    .clk          (clk),
    .arst_n       (arst_n),
    .cmd          (cmd_bus.regs),
    .printer_byte (printer_byte),
    .bus_addr_lo  (bus_addr[7:0]),  // for abus_read
    .screen_color (screen_color),
    .key_any      (key_any)
  );

  io_bridge #(
    .REQ_PULSE_CYCLES (REQ_PULSE_CYCLES)
  ) u_bridge (
    .clk          (clk),
    .arst_n       (arst_n),
    .bus_addr     (bus_addr),
    .bus_data     (bus_data),
    .in_n         (in_n),
    .out_n        (out_n),
    .wr_n         (wr_n),
    .rd_n         (rd_n),
    .esp_done     (esp_done),
    .esp_req      (esp_req),
    .esp_s        (esp_s),
    .wait_out     (wait_out),
    .io_int       (io_int),
    .bus_dout     (bus_dout),
    .printer_byte (printer_byte),
    .cmd          (cmd_bus.bridge)
  );

endmodule
